/* mem_pkg.sv */
package mem_pkg;

	localparam int xlen = 32; // data and address width.

	// memory-op field carried down from decode.
	typedef enum logic [3:0] {
		MEN_X   = 4'd0, // no memory access.
		MEN_LB  = 4'd1,
		MEN_LBU = 4'd2,
		MEN_LH  = 4'd3,
		MEN_LHU = 4'd4,
		MEN_LW  = 4'd5,
		MEN_SB  = 4'd6,
		MEN_SH  = 4'd7,
		MEN_SW  = 4'd8
	} mem_op_t;

	// command codes on the data memory port.
	typedef enum logic [1:0] {
		MEMORY_CMD_NOP   = 2'd0,
		MEMORY_CMD_READ  = 2'd1,
		MEMORY_CMD_WRITE = 2'd2
	} mem_cmd_t;

	localparam int wb_sel_w = 4; // write-back select field.

	// data memory geometry.
	localparam int mem_words = 256;
	localparam int mem_addr_w = $clog2(mem_words);

	// cycles from an accepted read command to the rdata_valid pulse.
	localparam int read_latency = 2;

	localparam logic [xlen-1:0] no_load_data = '1; // read_data after a non-memory op.

endpackage

/* mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if import mem_pkg::*; ();

	mem_cmd_t        cmd;         // one-cycle strobe.
	logic [xlen-1:0] addr;
	logic [xlen-1:0] wdata;
	logic [3:0]      wmask;       // byte enables.
	logic            cmd_ready;   // low while a read is outstanding.
	logic [xlen-1:0] rdata;
	logic            rdata_valid; // one-cycle pulse.

	// stage side.
	modport requester (
		output cmd,
		output addr,
		output wdata,
		output wmask,
		input  cmd_ready,
		input  rdata,
		input  rdata_valid
	);

	// memory side.
	modport responder (
		input  cmd,
		input  addr,
		input  wdata,
		input  wmask,
		output cmd_ready,
		output rdata,
		output rdata_valid
	);

endinterface

/* memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import mem_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [xlen-1:0]     reg_pc,
	input  logic [xlen-1:0]     rs2_data,
	input  logic [xlen-1:0]     alu_out,
	input  mem_op_t             mem_wen,
	input  logic [wb_sel_w-1:0] wb_sel,
	output logic [xlen-1:0]     read_data,
	output logic [xlen-1:0]     out_reg_pc,
	output logic [xlen-1:0]     out_alu_out,
	output logic [wb_sel_w-1:0] out_wb_sel,
	output logic                next_flg,
	output logic                stall,
	mem_port_if.requester       mem
);

	typedef enum logic [1:0] {
		s_wait,
		s_wait_ready,
		s_wait_read_valid,
		s_end
	} state_t;

	state_t              state;
	logic [xlen-1:0]     save_reg_pc;
	logic [xlen-1:0]     save_alu_out;
	logic [xlen-1:0]     save_rs2_data;
	mem_op_t             save_mem_wen;
	logic [wb_sel_w-1:0] save_wb_sel;
	logic [xlen-1:0]     load_data; // formatted load result, held until the end state.
	logic                is_store;
	logic [1:0]          lane;
	logic [xlen-1:0]     store_data;
	logic [3:0]          store_mask;

	// pick the addressed lane out of a word and extend it to xlen.
	function automatic logic [xlen-1:0] format_load(mem_op_t op, logic [1:0] off,
			logic [xlen-1:0] word);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[{off, 3'b000} +: 8];
		h = off[1] ? word[31:16] : word[15:0];
		case (op)
		MEN_LB:  format_load = {{24{b[7]}}, b};
		MEN_LBU: format_load = {24'b0, b};
		MEN_LH:  format_load = {{16{h[15]}}, h};
		MEN_LHU: format_load = {16'b0, h};
		default: format_load = word;
		endcase
	endfunction

	assign lane = save_alu_out[1:0];
	assign is_store = save_mem_wen inside {MEN_SB, MEN_SH, MEN_SW};

	// non-memory ops pass straight through in the idle state.
	assign next_flg = (state == s_wait && mem_wen == MEN_X) || state == s_end;
	assign stall = !next_flg;

	// the byte is replicated on all lanes and the mask picks the one that lands.
	always_comb begin
		case (save_mem_wen)
		MEN_SB: begin
			store_data = {4{save_rs2_data[7:0]}};
			store_mask = 4'b0001 << lane;
		end
		MEN_SH: begin
			store_data = {2{save_rs2_data[15:0]}};
			store_mask = lane[1] ? 4'b1100 : 4'b0011;
		end
		MEN_SW: begin
			store_data = save_rs2_data;
			store_mask = 4'b1111;
		end
		default: begin
			store_data = save_rs2_data;
			store_mask = 4'b0000;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_wait;
			mem.cmd <= MEMORY_CMD_NOP;
		end else begin
			mem.cmd <= MEMORY_CMD_NOP; // strobe lasts one cycle.
			case (state)
			s_wait: begin
				if (mem_wen != MEN_X) begin
					state <= s_wait_ready;
				end
			end
			s_wait_ready: begin
				if (mem.cmd_ready) begin
					if (is_store) begin
						mem.cmd <= MEMORY_CMD_WRITE;
						state <= s_end;
					end else begin
						mem.cmd <= MEMORY_CMD_READ;
						state <= s_wait_read_valid;
					end
				end
			end
			s_wait_read_valid: begin
				if (mem.rdata_valid) begin
					state <= s_end;
				end
			end
			default: state <= s_wait; // s_end.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
		s_wait: begin
			if (mem_wen != MEN_X) begin
				save_reg_pc <= reg_pc;
				save_alu_out <= alu_out;
				save_rs2_data <= rs2_data;
				save_mem_wen <= mem_wen;
				save_wb_sel <= wb_sel;
				load_data <= no_load_data; // stores keep this value.
			end else begin
				read_data <= no_load_data;
				out_reg_pc <= reg_pc;
				out_alu_out <= alu_out;
				out_wb_sel <= wb_sel;
			end
		end
		s_wait_ready: begin
			if (mem.cmd_ready) begin
				mem.addr <= save_alu_out;
				mem.wdata <= store_data;
				mem.wmask <= store_mask;
			end
		end
		s_wait_read_valid: begin
			if (mem.rdata_valid) begin
				load_data <= format_load(save_mem_wen, lane, mem.rdata);
			end
		end
		default: begin
			read_data <= load_data;
			out_reg_pc <= save_reg_pc;
			out_alu_out <= save_alu_out;
			out_wb_sel <= save_wb_sel;
		end
		endcase
	end

endmodule

/* data_memory.sv */
`timescale 1ns/1ps

module data_memory import mem_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,
	mem_port_if.responder  mem
);

	typedef logic [$clog2(read_latency + 1)-1:0] lat_cnt_t;

	logic [xlen-1:0]       mem_array [mem_words] = '{default: '0};
	lat_cnt_t              lat_cnt;      // cycles left on the outstanding read.
	lat_cnt_t              lat_cnt_next;
	logic [mem_addr_w-1:0] cmd_idx;
	logic [mem_addr_w-1:0] rd_idx;
	logic [mem_addr_w-1:0] fetch_idx;
	logic                  read_accept;
	logic                  write_accept;
	logic                  fetch;

	// word index with the byte offset dropped.
	assign cmd_idx = mem.addr[mem_addr_w+1:2];

	assign read_accept = mem.cmd == MEMORY_CMD_READ && mem.cmd_ready;
	assign write_accept = mem.cmd == MEMORY_CMD_WRITE;

	// writes finish in one cycle, so only a read holds the port.
	assign mem.cmd_ready = lat_cnt == '0;

	always_comb begin
		if (read_accept) begin
			lat_cnt_next = lat_cnt_t'(read_latency);
		end else if (lat_cnt != '0) begin
			lat_cnt_next = lat_cnt - 1'b1;
		end else begin
			lat_cnt_next = '0;
		end
	end

	// the word is fetched so that it shows up in the last busy cycle.
	assign fetch = lat_cnt_next == lat_cnt_t'(1);
	assign fetch_idx = read_accept ? cmd_idx : rd_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lat_cnt <= '0;
			mem.rdata_valid <= 1'b0;
		end else begin
			lat_cnt <= lat_cnt_next;
			mem.rdata_valid <= fetch;
		end
	end

	always_ff @(posedge clk) begin
		if (read_accept) begin
			rd_idx <= cmd_idx;
		end
		if (fetch) begin
			mem.rdata <= mem_array[fetch_idx];
		end
		if (write_accept) begin
			for (int b = 0; b < 4; b++) begin
				if (mem.wmask[b]) begin
					mem_array[cmd_idx][8*b +: 8] <= mem.wdata[8*b +: 8]; // enabled bytes only.
				end
			end
		end
	end

endmodule

/* memory_subsystem.sv */
`timescale 1ns/1ps

module memory_subsystem import mem_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [xlen-1:0]     reg_pc,
	input  logic [xlen-1:0]     rs2_data,
	input  logic [xlen-1:0]     alu_out,
	input  mem_op_t             mem_wen,
	input  logic [wb_sel_w-1:0] wb_sel,
	output logic [xlen-1:0]     read_data,
	output logic [xlen-1:0]     out_reg_pc,
	output logic [xlen-1:0]     out_alu_out,
	output logic [wb_sel_w-1:0] out_wb_sel,
	output logic                next_flg,
	output logic                stall
);

	mem_port_if mem_bus ();

	memory_stage u_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.reg_pc      (reg_pc),
		.rs2_data    (rs2_data),
		.alu_out     (alu_out),
		.mem_wen     (mem_wen),
		.wb_sel      (wb_sel),
		.read_data   (read_data),
		.out_reg_pc  (out_reg_pc),
		.out_alu_out (out_alu_out),
		.out_wb_sel  (out_wb_sel),
		.next_flg    (next_flg),
		.stall       (stall),
		.mem         (mem_bus.requester)
	);

	data_memory u_memory (
		.clk   (clk),
		.rst_n (rst_n),
		.mem   (mem_bus.responder)
	);

endmodule

/* memory_subsystem_sva.sv */
`timescale 1ns/1ps

module memory_subsystem_sva import mem_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input mem_cmd_t cmd,
	input logic     cmd_ready,
	input logic     rdata_valid,
	input mem_op_t  mem_wen,
	input logic     next_flg,
	input logic     stall
);

	int unsigned fail_count = 0; // failed assertions so far.

	cmd_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		cmd != MEMORY_CMD_NOP |=> cmd == MEMORY_CMD_NOP)
	else begin
		$error("memory command held for two cycles");
		fail_count++;
	end

	// a command may only follow a cycle where the memory was ready.
	cmd_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
		cmd != MEMORY_CMD_NOP |-> $past(cmd_ready))
	else begin
		$error("memory command issued while the memory was busy");
		fail_count++;
	end

	read_gets_valid: assert property (@(posedge clk) disable iff (!rst_n)
		cmd == MEMORY_CMD_READ |-> ##read_latency rdata_valid)
	else begin
		$error("read data did not arrive after the read latency");
		fail_count++;
	end

	valid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
		rdata_valid |-> $past(cmd == MEMORY_CMD_READ, read_latency))
	else begin
		$error("read valid pulse without a matching read command");
		fail_count++;
	end

	stall_inverse: assert property (@(posedge clk) disable iff (!rst_n)
		stall == !next_flg)
	else begin
		$error("stall is not the inverse of next_flg");
		fail_count++;
	end

	idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) && mem_wen == MEN_X |-> !stall)
	else begin
		$error("stage stalls right after reset with no memory op");
		fail_count++;
	end

endmodule

bind memory_subsystem memory_subsystem_sva u_sva (
	.clk         (clk),
	.rst_n       (rst_n),
	.cmd         (mem_bus.cmd),
	.cmd_ready   (mem_bus.cmd_ready),
	.rdata_valid (mem_bus.rdata_valid),
	.mem_wen     (mem_wen),
	.next_flg    (next_flg),
	.stall       (stall)
);

/* tb_memory_subsystem.sv */
`timescale 1ns/1ps

module tb_memory_subsystem import mem_pkg::*; ();

	localparam int instr_count = 2 + 8 + 18 + 26 + 4 + 40; // instructions per test.
	// worst case is a load at 4 + read_latency cycles.
	localparam int timeout_cycles = 2 * (instr_count * (4 + read_latency) + 2);

	logic                clk;
	logic                rst_n;
	logic [xlen-1:0]     reg_pc;
	logic [xlen-1:0]     rs2_data;
	logic [xlen-1:0]     alu_out;
	mem_op_t             mem_wen;
	logic [wb_sel_w-1:0] wb_sel;
	logic [xlen-1:0]     read_data;
	logic [xlen-1:0]     out_reg_pc;
	logic [xlen-1:0]     out_alu_out;
	logic [wb_sel_w-1:0] out_wb_sel;
	logic                next_flg;
	logic                stall;

	logic        flg_q;        // next_flg as seen at the last rising edge.
	logic [15:0] lfsr = 16'd46;
	logic [7:0]  model [1024]; // byte image of the data memory.
	logic [31:0] next_pc = 32'h0000_1000;
	int          errors = 0;
	int          checks = 0;
	int          tests_failed = 0;
	int          cycle_cnt = 0;

	memory_subsystem uut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		flg_q <= next_flg;
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			$display("run timed out after %0d cycles without finishing", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16 + x^14 + x^13 + x^11 + 1.
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] addr);
		logic [9:0]  a;
		logic [7:0]  b;
		logic [15:0] h;
		a = addr[9:0];
		b = model[a];
		h = {model[{a[9:1], 1'b1}], model[{a[9:1], 1'b0}]};
		case (op)
		MEN_LB:  return {{24{b[7]}}, b};
		MEN_LBU: return {24'b0, b};
		MEN_LH:  return {{16{h[15]}}, h};
		MEN_LHU: return {16'b0, h};
		default: return {model[{a[9:2], 2'd3}], model[{a[9:2], 2'd2}],
			model[{a[9:2], 2'd1}], model[{a[9:2], 2'd0}]};
		endcase
	endfunction

	task automatic store_to_model(input mem_op_t op, input logic [31:0] addr,
			input logic [31:0] data);
		case (op)
		MEN_SB: model[addr[9:0]] = data[7:0];
		MEN_SH: begin
			model[{addr[9:1], 1'b0}] = data[7:0];
			model[{addr[9:1], 1'b1}] = data[15:8];
		end
		default: begin
			for (int i = 0; i < 4; i++) begin
				model[{addr[9:2], 2'(i)}] = data[8*i +: 8];
			end
		end
		endcase
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic drive_inputs(input mem_op_t op, input logic [31:0] pc,
			input logic [31:0] alu, input logic [31:0] rs2, input logic [3:0] wb);
		mem_wen = op;
		reg_pc = pc;
		alu_out = alu;
		rs2_data = rs2;
		wb_sel = wb;
	endtask

	// runs until the negedge after next_flg was high at a rising edge.
	task automatic wait_done(output int waited, output int stalled);
		logic done;
		done = 1'b0;
		waited = 0;
		stalled = 0;
		while (!done) begin
			@(negedge clk);
			waited++;
			if (flg_q) begin
				done = 1'b1;
			end else if (stall) begin
				stalled++;
			end
		end
	endtask

	task automatic execute(input mem_op_t op, input logic [31:0] alu, input logic [31:0] rs2);
		logic [31:0] pc;
		logic [3:0]  wb;
		logic [31:0] exp;
		int          waited;
		int          stalled;
		pc = next_pc;
		wb = pc[5:2];
		next_pc = next_pc + 4;
		exp = expected_load(op, alu);
		drive_inputs(op, pc, alu, rs2, wb);
		wait_done(waited, stalled);
		check_value("out_reg_pc", out_reg_pc, pc);
		check_value("out_alu_out", out_alu_out, alu);
		check_value("out_wb_sel", out_wb_sel, wb);
		if (op == MEN_X) begin
			check_value("cycles to next_flg", waited, 1);
			check_value("read_data", read_data, 32'hffff_ffff);
		end else begin
			check_value("stall cycles", stalled, waited - 2);
			if (op inside {MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW}) begin
				check_value("read_data", read_data, exp);
			end else begin
				store_to_model(op, alu, rs2);
			end
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
			tests_failed++;
		end
	endtask

	initial begin
		mem_op_t     ops [8];
		logic [31:0] addr;
		logic [31:0] pc;
		logic [31:0] word;
		mem_op_t     op;
		int          e;
		int          w;
		int          s;
		ops = '{MEN_LB, MEN_LBU, MEN_LH, MEN_LHU, MEN_LW, MEN_SB, MEN_SH, MEN_SW};
		for (int i = 0; i < 1024; i++) begin
			model[i] = 8'h00;
		end
		rst_n = 1'b0;
		drive_inputs(MEN_X, '0, '0, '0, '0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		e = errors;
		execute(MEN_X, lfsr_bits(32), lfsr_bits(32));
		execute(MEN_X, lfsr_bits(32), lfsr_bits(32));
		report_test("non_memory", e);

		e = errors;
		for (int i = 0; i < 4; i++) begin
			addr = lfsr_bits(8) << 2;
			execute(MEN_SW, addr, lfsr_bits(32));
			execute(MEN_LW, addr, '0);
		end
		report_test("word_store_load", e);

		e = errors;
		for (int off = 0; off < 4; off++) begin
			execute(MEN_SW, 32'h300, 32'h1122_3344);
			execute(MEN_SB, 32'h300 + off, lfsr_bits(32));
			execute(MEN_LW, 32'h300, '0);
		end
		for (int off = 0; off < 4; off += 2) begin
			execute(MEN_SW, 32'h300, 32'h1122_3344);
			execute(MEN_SH, 32'h300 + off, lfsr_bits(32));
			execute(MEN_LW, 32'h300, '0);
		end
		report_test("sub_word_store", e);

		e = errors;
		for (int k = 0; k < 2; k++) begin
			word = (k == 0) ? 32'h8a9b_acbd : 32'h1a2b_3c4d; // lane top bits set on pass 0.
			execute(MEN_SW, 32'h380, word);
			for (int off = 0; off < 4; off++) begin
				execute(MEN_LB, 32'h380 + off, '0);
				execute(MEN_LBU, 32'h380 + off, '0);
			end
			for (int off = 0; off < 4; off += 2) begin
				execute(MEN_LH, 32'h380 + off, '0);
				execute(MEN_LHU, 32'h380 + off, '0);
			end
		end
		report_test("load_extension", e);

		e = errors;
		execute(MEN_SW, 32'h100, 32'h1234_5678);
		execute(MEN_SW, 32'h104, 32'hcafe_f00d);
		pc = next_pc;
		next_pc = next_pc + 4;
		drive_inputs(MEN_LW, pc, 32'h100, '0, pc[5:2]);
		@(negedge clk);
		check_value("stall after accept", stall, 1);
		drive_inputs(MEN_SW, pc + 32'h40, 32'h104, 32'hdead_beef, 4'hf); // must be ignored.
		wait_done(w, s);
		check_value("out_reg_pc", out_reg_pc, pc);
		check_value("out_alu_out", out_alu_out, 32'h100);
		check_value("out_wb_sel", out_wb_sel, pc[5:2]);
		check_value("read_data", read_data, expected_load(MEN_LW, 32'h100));
		check_value("stall cycles", s, w - 2);
		execute(MEN_LW, 32'h104, '0);
		report_test("stall", e);

		e = errors;
		for (int i = 0; i < 40; i++) begin
			op = ops[lfsr_bits(3)];
			addr = 32'h200 | lfsr_bits(6);
			if (op inside {MEN_LH, MEN_LHU, MEN_SH}) begin
				addr[0] = 1'b0;
			end else if (op inside {MEN_LW, MEN_SW}) begin
				addr[1:0] = 2'b00;
			end
			execute(op, addr, lfsr_bits(32));
		end
		report_test("random_mix", e);

		drive_inputs(MEN_X, '0, '0, '0, '0);
		@(negedge clk);
		$display("6 tests, %0d passed, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			6 - tests_failed, tests_failed, checks, errors, uut.u_sva.fail_count);
		if (errors == 0 && uut.u_sva.fail_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* sources.f */
mem_pkg.sv
mem_port_if.sv
memory_stage.sv
data_memory.sv
memory_subsystem.sv
memory_subsystem_sva.sv
tb_memory_subsystem.sv

/* Makefile */
TOP = tb_memory_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
